/* hdl/udma_defines.svh */
// channel count, bus widths, register map offsets and L2 read outstanding limit
`ifndef UDMA_DEFINES_SVH
`define UDMA_DEFINES_SVH

// number of linear transmit channels
`define UDMA_N_CH            4

// L2 read port
`define UDMA_ADDR_W          32
`define UDMA_DATA_W          32

// reads the L2 port may have in flight
`define UDMA_MAX_OUTSTANDING 2

// APB configuration bus
`define UDMA_APB_ADDR_W      12
`define UDMA_SIZE_W          16

// register map, one group of registers per channel
`define UDMA_CH_STRIDE       16
`define UDMA_REG_SADDR       0
`define UDMA_REG_SIZE        4
`define UDMA_REG_CFG         8

`endif

/* hdl/udma_pkg.sv */
// shared typedefs for addresses, data, sizes, channel ids and the channel FSM state
`include "udma_defines.svh"

package udma_pkg;

    // L2 byte address and data word
    typedef logic [`UDMA_ADDR_W-1:0] l2_addr_t;
    typedef logic [`UDMA_DATA_W-1:0] l2_data_t;

    // transfer length in bytes, as held in the SIZE register
    typedef logic [`UDMA_SIZE_W-1:0] xfer_size_t;

    // channel number
    typedef logic [$clog2(`UDMA_N_CH)-1:0] ch_id_t;

    // one bit per channel
    typedef logic [`UDMA_N_CH-1:0] ch_mask_t;

    typedef logic [`UDMA_APB_ADDR_W-1:0] apb_addr_t;

    // linear channel FSM
    // DRAIN waits for the words already requested
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        RUN   = 2'd1,
        DRAIN = 2'd2
    } ch_state_e;

endpackage

/* hdl/udma_apb_regs.sv */
// APB register block with per-channel start address, size, start pulse and busy readback
`include "udma_defines.svh"

module udma_apb_regs (
    input  logic                                  sys_clk_i,
    input  logic                                  arst_n_i,

    // APB slave
    input  udma_pkg::apb_addr_t                   paddr_i,
    input  logic [31:0]                           pwdata_i,
    input  logic                                  pwrite_i,
    input  logic                                  psel_i,
    input  logic                                  penable_i,
    output logic [31:0]                           prdata_o,
    output logic                                  pready_o,
    output logic                                  pslverr_o,

    // channel control
    input  udma_pkg::ch_mask_t                    ch_busy_i,
    output udma_pkg::ch_mask_t                    ch_start_o,
    output udma_pkg::l2_addr_t   [`UDMA_N_CH-1:0] ch_saddr_o,
    output udma_pkg::xfer_size_t [`UDMA_N_CH-1:0] ch_size_o
);
    import udma_pkg::*;

    localparam int OFF_W = $clog2(`UDMA_CH_STRIDE);
    localparam int ID_W  = $bits(ch_id_t);

    logic [OFF_W-1:0] reg_off;
    ch_id_t           grp_idx;
    logic             grp_hit;
    logic             off_hit;
    logic             addr_ok;
    logic             apb_access;
    logic             wr_en;

    l2_addr_t   [`UDMA_N_CH-1:0] saddr_q;
    xfer_size_t [`UDMA_N_CH-1:0] size_q;
    ch_mask_t                    start_q;

    // address split into channel group and offset
    assign reg_off = paddr_i[OFF_W-1:0];
    assign grp_idx = paddr_i[OFF_W +: ID_W];
    assign grp_hit = (paddr_i >> OFF_W) < `UDMA_N_CH;

    assign off_hit = (reg_off == OFF_W'(`UDMA_REG_SADDR)) ||
                     (reg_off == OFF_W'(`UDMA_REG_SIZE))  ||
                     (reg_off == OFF_W'(`UDMA_REG_CFG));

    assign addr_ok    = grp_hit && off_hit;
    assign apb_access = psel_i && penable_i;
    assign wr_en      = apb_access && pwrite_i && addr_ok;

    // no wait states
    assign pready_o  = 1'b1;
    assign pslverr_o = apb_access && !addr_ok;

    // read mux, zero for unmapped offsets
    always_comb begin
        prdata_o = '0;
        if (addr_ok) begin
            case (reg_off)
                OFF_W'(`UDMA_REG_SADDR): prdata_o = saddr_q[grp_idx];
                OFF_W'(`UDMA_REG_SIZE):  prdata_o = 32'(size_q[grp_idx]);
                OFF_W'(`UDMA_REG_CFG):   prdata_o = 32'(ch_busy_i[grp_idx]);
                default:                 prdata_o = '0;
            endcase
        end
    end

    always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            saddr_q <= '0;
            size_q  <= '0;
            start_q <= '0;
        end else begin
            // start is a single cycle pulse
            start_q <= '0;
            if (wr_en) begin
                case (reg_off)
                    OFF_W'(`UDMA_REG_SADDR): begin
                        saddr_q[grp_idx] <= l2_addr_t'(pwdata_i);
                    end
                    OFF_W'(`UDMA_REG_SIZE): begin
                        size_q[grp_idx] <= pwdata_i[`UDMA_SIZE_W-1:0];
                    end
                    OFF_W'(`UDMA_REG_CFG): begin
                        start_q[grp_idx] <= pwdata_i[0];
                    end
                    default: begin
                        start_q <= '0;
                    end
                endcase
            end
        end
    end

    assign ch_start_o = start_q;
    assign ch_saddr_o = saddr_q;
    assign ch_size_o  = size_q;

endmodule

/* hdl/udma_tx_channel.sv */
// linear transmit channel with L2 address generation, word counting and end-of-transfer pulse
module udma_tx_channel (
    input  logic                 sys_clk_i,
    input  logic                 arst_n_i,

    // configuration
    input  logic                 start_i,
    input  udma_pkg::l2_addr_t   saddr_i,
    input  udma_pkg::xfer_size_t size_i,

    // arbiter side
    input  logic                 gnt_i,
    input  logic                 rvalid_i,
    output logic                 req_o,
    output udma_pkg::l2_addr_t   addr_o,

    // status
    output logic                 busy_o,
    output logic                 eot_o
);
    import udma_pkg::*;

    ch_state_e  state_q;
    ch_state_e  state_d;
    l2_addr_t   addr_q;
    xfer_size_t req_left_q;
    xfer_size_t rsp_left_q;
    xfer_size_t size_words;
    logic       start_ok;
    logic       issue;
    logic       last_req;
    logic       last_rsp;
    logic       eot_q;

    // whole words only, a trailing partial word is dropped
    assign size_words = size_i >> 2;

    // ignored while busy or for an empty transfer
    assign start_ok = start_i && (state_q == IDLE) && (size_words != '0);

    assign issue    = req_o && gnt_i;
    assign last_req = issue && (req_left_q == xfer_size_t'(1));
    assign last_rsp = rvalid_i && (rsp_left_q == xfer_size_t'(1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start_ok) begin
                    state_d = RUN;
                end
            end
            RUN: begin
                if (last_req) begin
                    state_d = DRAIN;
                end
            end
            DRAIN: begin
                if (last_rsp) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= IDLE;
            addr_q     <= '0;
            req_left_q <= '0;
            rsp_left_q <= '0;
            eot_q      <= 1'b0;
        end else begin
            state_q <= state_d;
            // last word came back, busy drops together with this pulse
            eot_q   <= (state_q == DRAIN) && last_rsp;
            if (start_ok) begin
                addr_q     <= saddr_i;
                req_left_q <= size_words;
                rsp_left_q <= size_words;
            end else begin
                if (issue) begin
                    addr_q     <= addr_q + l2_addr_t'(4);
                    req_left_q <= req_left_q - xfer_size_t'(1);
                end
                if (rvalid_i && busy_o) begin
                    rsp_left_q <= rsp_left_q - xfer_size_t'(1);
                end
            end
        end
    end

    // address is held until granted
    assign req_o  = (state_q == RUN);
    assign addr_o = addr_q;
    assign busy_o = (state_q != IDLE);
    assign eot_o  = eot_q;

endmodule

/* hdl/udma_l2_arbiter.sv */
// round-robin arbiter for the shared L2 read port with an owner queue for returning data
`include "udma_defines.svh"

module udma_l2_arbiter (
    input  logic                                sys_clk_i,
    input  logic                                arst_n_i,

    // channel side
    input  udma_pkg::ch_mask_t                  ch_req_i,
    input  udma_pkg::l2_addr_t [`UDMA_N_CH-1:0] ch_addr_i,
    output udma_pkg::ch_mask_t                  ch_gnt_o,
    output udma_pkg::ch_mask_t                  ch_rvalid_o,

    // L2 read only port
    output logic                                l2_req_o,
    output udma_pkg::l2_addr_t                  l2_addr_o,
    input  logic                                l2_gnt_i,
    input  logic                                l2_rvalid_i,
    input  udma_pkg::l2_data_t                  l2_rdata_i,

    // outgoing data strobe
    output logic                                tx_valid_o,
    output udma_pkg::ch_id_t                    tx_ch_o,
    output udma_pkg::l2_data_t                  tx_data_o
);
    import udma_pkg::*;

    localparam int DEPTH = `UDMA_MAX_OUTSTANDING;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    ch_id_t           owner_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] cnt_q;
    logic             q_full;
    logic             q_empty;
    ch_id_t           head;
    ch_id_t           last_q;
    ch_id_t           rr_sel;
    logic             rr_any;
    ch_id_t           sel;
    logic             lock_q;
    ch_id_t           lock_ch_q;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // search starts just after the last granted channel
    always_comb begin
        ch_id_t idx;
        rr_any = 1'b0;
        rr_sel = last_q;
        for (int i = 1; i <= `UDMA_N_CH; i++) begin
            idx = ch_id_t'((int'(last_q) + i) % `UDMA_N_CH);
            if (!rr_any && ch_req_i[idx]) begin
                rr_any = 1'b1;
                rr_sel = idx;
            end
        end
    end

    // a pending request keeps its channel until L2 grants it
    assign sel = lock_q ? lock_ch_q : rr_sel;

    assign q_full  = (cnt_q == CNT_W'(DEPTH));
    assign q_empty = (cnt_q == '0);
    assign head    = owner_q[rd_ptr_q];

    assign l2_req_o  = (lock_q || rr_any) && !q_full;
    assign l2_addr_o = ch_addr_i[sel];

    assign push = l2_req_o && l2_gnt_i;
    assign pop  = l2_rvalid_i && !q_empty;

    assign ch_gnt_o    = push ? (ch_mask_t'(1) << sel) : '0;
    assign ch_rvalid_o = pop ? (ch_mask_t'(1) << head) : '0;

    // data goes straight out, tagged with the oldest owner
    assign tx_valid_o = pop;
    assign tx_ch_o    = head;
    assign tx_data_o  = l2_rdata_i;

    always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            owner_q   <= '{default: '0};
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            cnt_q     <= '0;
            last_q    <= ch_id_t'(`UDMA_N_CH - 1);
            lock_q    <= 1'b0;
            lock_ch_q <= '0;
        end else begin
            if (push) begin
                owner_q[wr_ptr_q] <= sel;
                wr_ptr_q          <= ptr_next(wr_ptr_q);
                last_q            <= sel;
            end
            if (pop) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            if (push && !pop) begin
                cnt_q <= cnt_q + 1'b1;
            end else if (pop && !push) begin
                cnt_q <= cnt_q - 1'b1;
            end
            lock_q <= l2_req_o && !l2_gnt_i;
            if (l2_req_o && !l2_gnt_i) begin
                lock_ch_q <= sel;
            end
        end
    end

endmodule

/* hdl/udma_subsystem.sv */
// transmit subsystem top with APB registers, four linear channels and the L2 read arbiter
`include "udma_defines.svh"

module udma_subsystem (
    input  logic                 sys_clk_i,
    input  logic                 arst_n_i,

    // APB configuration bus
    input  udma_pkg::apb_addr_t  paddr_i,
    input  logic [31:0]          pwdata_i,
    input  logic                 pwrite_i,
    input  logic                 psel_i,
    input  logic                 penable_i,
    output logic [31:0]          prdata_o,
    output logic                 pready_o,
    output logic                 pslverr_o,

    // L2 read only port
    output logic                 l2_req_o,
    output udma_pkg::l2_addr_t   l2_addr_o,
    input  logic                 l2_gnt_i,
    input  logic                 l2_rvalid_i,
    input  udma_pkg::l2_data_t   l2_rdata_i,

    // outgoing data and end-of-transfer events
    output logic                 tx_valid_o,
    output udma_pkg::ch_id_t     tx_ch_o,
    output udma_pkg::l2_data_t   tx_data_o,
    output udma_pkg::ch_mask_t   events_o
);
    import udma_pkg::*;

    ch_mask_t                    ch_start;
    ch_mask_t                    ch_busy;
    ch_mask_t                    ch_req;
    ch_mask_t                    ch_gnt;
    ch_mask_t                    ch_rvalid;
    l2_addr_t   [`UDMA_N_CH-1:0] ch_saddr;
    l2_addr_t   [`UDMA_N_CH-1:0] ch_addr;
    xfer_size_t [`UDMA_N_CH-1:0] ch_size;

    udma_apb_regs i_apb_regs (
        .sys_clk_i   ( sys_clk_i  ),
        .arst_n_i    ( arst_n_i   ),
        .paddr_i     ( paddr_i    ),
        .pwdata_i    ( pwdata_i   ),
        .pwrite_i    ( pwrite_i   ),
        .psel_i      ( psel_i     ),
        .penable_i   ( penable_i  ),
        .prdata_o    ( prdata_o   ),
        .pready_o    ( pready_o   ),
        .pslverr_o   ( pslverr_o  ),
        .ch_busy_i   ( ch_busy    ),
        .ch_start_o  ( ch_start   ),
        .ch_saddr_o  ( ch_saddr   ),
        .ch_size_o   ( ch_size    )
    );

    // one linear channel per event bit
    for (genvar g_ch = 0; g_ch < `UDMA_N_CH; g_ch++) begin : gen_tx_ch
        udma_tx_channel i_tx_channel (
            .sys_clk_i ( sys_clk_i        ),
            .arst_n_i  ( arst_n_i         ),
            .start_i   ( ch_start[g_ch]   ),
            .saddr_i   ( ch_saddr[g_ch]   ),
            .size_i    ( ch_size[g_ch]    ),
            .gnt_i     ( ch_gnt[g_ch]     ),
            .rvalid_i  ( ch_rvalid[g_ch]  ),
            .req_o     ( ch_req[g_ch]     ),
            .addr_o    ( ch_addr[g_ch]    ),
            .busy_o    ( ch_busy[g_ch]    ),
            .eot_o     ( events_o[g_ch]   )
        );
    end : gen_tx_ch

    udma_l2_arbiter i_l2_arbiter (
        .sys_clk_i   ( sys_clk_i   ),
        .arst_n_i    ( arst_n_i    ),
        .ch_req_i    ( ch_req      ),
        .ch_addr_i   ( ch_addr     ),
        .ch_gnt_o    ( ch_gnt      ),
        .ch_rvalid_o ( ch_rvalid   ),
        .l2_req_o    ( l2_req_o    ),
        .l2_addr_o   ( l2_addr_o   ),
        .l2_gnt_i    ( l2_gnt_i    ),
        .l2_rvalid_i ( l2_rvalid_i ),
        .l2_rdata_i  ( l2_rdata_i  ),
        .tx_valid_o  ( tx_valid_o  ),
        .tx_ch_o     ( tx_ch_o     ),
        .tx_data_o   ( tx_data_o   )
    );

endmodule

/* bench/udma_tb_mem.svh */
// L2 memory contents as a function of the byte address
function automatic l2_data_t mem_word(input l2_addr_t addr);
    l2_data_t mixed;
    mixed = addr ^ 32'h5a3c_96e1;
    return {mixed[18:0], mixed[31:19]};
endfunction

/* bench/udma_checker.sv */
// monitor and scoreboard for APB responses, L2 request, data strobes and end-of-transfer events
`include "udma_defines.svh"

module udma_checker (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  udma_pkg::apb_addr_t paddr_i,
    input  logic [31:0]         pwdata_i,
    input  logic                pwrite_i,
    input  logic                psel_i,
    input  logic                penable_i,
    input  logic [31:0]         prdata_i,
    input  logic                pready_i,
    input  logic                pslverr_i,
    input  logic                l2_req_i,
    input  logic                tx_valid_i,
    input  udma_pkg::ch_id_t    tx_ch_i,
    input  udma_pkg::l2_data_t  tx_data_i,
    input  udma_pkg::ch_mask_t  events_i,
    output int                  err_cnt_o,
    output int                  word_cnt_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import udma_pkg::*;

    `include "udma_tb_mem.svh"

    // register shadow and per-channel progress
    l2_addr_t   saddr    [`UDMA_N_CH];
    xfer_size_t size     [`UDMA_N_CH];
    l2_addr_t   exp_addr [`UDMA_N_CH];
    int         left     [`UDMA_N_CH];
    ch_mask_t   active;
    ch_mask_t   eot_due;

    task automatic report(input string sig, input logic [31:0] exp, input logic [31:0] act);
        $display("FAILED at %0t ns: %s expected 0x%08h, got 0x%08h", $time, sig, exp, act);
        err_cnt_o++;
    endtask

    function automatic logic [31:0] expected_read(input int grp, input int off);
        case (off)
            `UDMA_REG_SADDR: return saddr[grp];
            `UDMA_REG_SIZE:  return 32'(size[grp]);
            `UDMA_REG_CFG:   return 32'(active[grp]);
            default:         return '0;
        endcase
    endfunction

    always @(posedge clk_i or negedge arst_n_i) begin
        int          grp;
        int          off;
        logic        addr_ok;
        logic [31:0] exp_rd;
        if (!arst_n_i) begin
            active     = '0;
            eot_due    = '0;
            err_cnt_o  = 0;
            word_cnt_o = 0;
            saddr      = '{default: '0};
            size       = '{default: '0};
        end else begin
            grp     = int'(paddr_i) / `UDMA_CH_STRIDE;
            off     = int'(paddr_i) % `UDMA_CH_STRIDE;
            addr_ok = (grp < `UDMA_N_CH) && (off == `UDMA_REG_SADDR ||
                      off == `UDMA_REG_SIZE || off == `UDMA_REG_CFG);
            // busy is taken before this cycle's words are counted
            if (psel_i && penable_i) begin
                // every access completes in its enable phase
                if (pready_i !== 1'b1)
                    report("pready_o", 32'd1, 32'(pready_i));
                if (pslverr_i !== !addr_ok)
                    report("pslverr_o", 32'(!addr_ok), 32'(pslverr_i));
                exp_rd = addr_ok ? expected_read(grp, off) : '0;
                if (!pwrite_i && prdata_i !== exp_rd)
                    report("prdata_o", exp_rd, prdata_i);
                if (pwrite_i && addr_ok) begin
                    case (off)
                        `UDMA_REG_SADDR: saddr[grp] = pwdata_i;
                        `UDMA_REG_SIZE:  size[grp] = pwdata_i[`UDMA_SIZE_W-1:0];
                        default: begin
                            // start ignored while busy or under one word
                            if (pwdata_i[0] && !active[grp] && (size[grp] >> 2) != 0) begin
                                active[grp]   = 1'b1;
                                exp_addr[grp] = saddr[grp];
                                left[grp]     = int'(size[grp] >> 2);
                            end
                        end
                    endcase
                end
            end
            // event is due exactly one cycle after the last word
            if (events_i !== eot_due)
                report("events_o", 32'(eot_due), 32'(events_i));
            eot_due = '0;
            if (active == '0 && l2_req_i !== 1'b0)
                report("l2_req_o", 32'd0, 32'(l2_req_i));
            if (tx_valid_i) begin
                if (!active[tx_ch_i]) begin
                    $display("ERROR at %0t ns: data strobe on channel %0d with no transfer running",
                             $time, tx_ch_i);
                    err_cnt_o++;
                end else begin
                    if (tx_data_i !== mem_word(exp_addr[tx_ch_i]))
                        report("tx_data_o", mem_word(exp_addr[tx_ch_i]), tx_data_i);
                    exp_addr[tx_ch_i] = exp_addr[tx_ch_i] + 4;
                    left[tx_ch_i]     = left[tx_ch_i] - 1;
                    word_cnt_o++;
                    if (left[tx_ch_i] == 0) begin
                        active[tx_ch_i]  = 1'b0;
                        eot_due[tx_ch_i] = 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* bench/tb_udma_subsystem.sv */
// testbench top with clock, reset, APB driver, L2 memory model, test sequence and timeout
`include "udma_defines.svh"

module tb_udma_subsystem;
    timeunit 1ns;
    timeprecision 1ps;
    import udma_pkg::*;

    `include "udma_tb_mem.svh"

    // words of the single channel test and the four channel test
    localparam int TOTAL_WORDS = 16 + 8 + 12 + 6 + 10;
    localparam int MAX_CYCLES  = 2 * TOTAL_WORDS * 8 + 2000;

    logic        sys_clk_i;
    logic        arst_n_i;
    apb_addr_t   paddr_i;
    logic [31:0] pwdata_i;
    logic        pwrite_i;
    logic        psel_i;
    logic        penable_i;
    logic [31:0] prdata_o;
    logic        pready_o;
    logic        pslverr_o;
    logic        l2_req_o;
    l2_addr_t    l2_addr_o;
    logic        l2_gnt_i;
    logic        l2_rvalid_i;
    l2_data_t    l2_rdata_i;
    logic        tx_valid_o;
    ch_id_t      tx_ch_o;
    l2_data_t    tx_data_o;
    ch_mask_t    events_o;
    logic        rand_gnt;
    int          seed;
    int          cycles;
    int          err_cnt;
    int          word_cnt;
    int          test_num;
    int          test_base;

    udma_subsystem uut (.*);

    udma_checker u_checker (
        .*,
        .clk_i      ( sys_clk_i  ),
        .prdata_i   ( prdata_o   ),
        .pready_i   ( pready_o   ),
        .pslverr_i  ( pslverr_o  ),
        .l2_req_i   ( l2_req_o   ),
        .tx_valid_i ( tx_valid_o ),
        .tx_ch_i    ( tx_ch_o    ),
        .tx_data_i  ( tx_data_o  ),
        .events_i   ( events_o   ),
        .err_cnt_o  ( err_cnt    ),
        .word_cnt_o ( word_cnt   )
    );

    initial begin
        sys_clk_i = 1'b0;
        forever #20 sys_clk_i = ~sys_clk_i;
    end

    // L2 model, each accepted read answers one cycle later in order
    always @(posedge sys_clk_i) begin
        l2_gnt_i    <= rand_gnt ? 1'($random(seed)) : 1'b1;
        l2_rvalid_i <= l2_req_o && l2_gnt_i;
        l2_rdata_i  <= mem_word(l2_addr_o);
    end

    always @(posedge sys_clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run timed out after %0d cycles", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic int reg_addr(input int ch, input int off);
        return ch * `UDMA_CH_STRIDE + off;
    endfunction

    // setup phase then enable phase
    task automatic apb_access(input int addr, input logic [31:0] data, input logic write);
        @(posedge sys_clk_i);
        paddr_i   <= apb_addr_t'(addr);
        pwdata_i  <= data;
        pwrite_i  <= write;
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        @(posedge sys_clk_i);
        penable_i <= 1'b1;
        @(posedge sys_clk_i);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic setup_channel(input int ch, input l2_addr_t saddr, input int size);
        apb_access(reg_addr(ch, `UDMA_REG_SADDR), saddr, 1'b1);
        apb_access(reg_addr(ch, `UDMA_REG_SIZE), 32'(size), 1'b1);
    endtask

    task automatic wait_events(input ch_mask_t mask);
        ch_mask_t seen;
        seen = '0;
        while ((seen & mask) != mask) begin
            @(negedge sys_clk_i);
            seen = seen | events_o;
        end
    endtask

    task automatic end_test(input string name);
        repeat (4) @(posedge sys_clk_i);
        @(negedge sys_clk_i);
        $display("test %0d %s: %0d errors, %0d words so far",
                 test_num, name, err_cnt - test_base, word_cnt);
        test_num++;
        test_base = err_cnt;
    endtask

    initial begin
        seed        = 32'h890a_c3f2;
        cycles      = 0;
        test_num    = 1;
        test_base   = 0;
        rand_gnt    = 1'b0;
        arst_n_i    = 1'b0;
        paddr_i     = '0;
        pwdata_i    = '0;
        pwrite_i    = 1'b0;
        psel_i      = 1'b0;
        penable_i   = 1'b0;
        l2_gnt_i    = 1'b0;
        l2_rvalid_i = 1'b0;
        l2_rdata_i  = '0;
        repeat (10) @(posedge sys_clk_i);
        arst_n_i <= 1'b1;

        repeat (20) @(posedge sys_clk_i);
        for (int c = 0; c < `UDMA_N_CH; c++)
            apb_access(reg_addr(c, `UDMA_REG_CFG), '0, 1'b0);
        end_test("idle after reset");

        for (int c = 0; c < `UDMA_N_CH; c++) begin
            setup_channel(c, 32'h2000_0000 + c * 32'h0101_0010, 16'h0100 + c * 12);
            apb_access(reg_addr(c, `UDMA_REG_SADDR), '0, 1'b0);
            apb_access(reg_addr(c, `UDMA_REG_SIZE), '0, 1'b0);
        end
        // offset 12 and the space past the last group
        apb_access(reg_addr(0, 12), 32'hdead_beef, 1'b1);
        apb_access(reg_addr(2, 12), '0, 1'b0);
        apb_access(reg_addr(`UDMA_N_CH, `UDMA_REG_SADDR), 32'h1234_5678, 1'b1);
        apb_access(reg_addr(`UDMA_N_CH, `UDMA_REG_SADDR), '0, 1'b0);
        apb_access(reg_addr(255, `UDMA_REG_CFG), '0, 1'b0);
        // stray writes leave channel 0 untouched
        apb_access(reg_addr(0, `UDMA_REG_SADDR), '0, 1'b0);
        apb_access(reg_addr(0, `UDMA_REG_SIZE), '0, 1'b0);
        end_test("register access");

        setup_channel(1, 32'h0000_1000, 64);
        apb_access(reg_addr(1, `UDMA_REG_CFG), 32'h1, 1'b1);
        wait_events(4'b0010);
        apb_access(reg_addr(1, `UDMA_REG_CFG), '0, 1'b0);
        end_test("single channel");

        rand_gnt <= 1'b1;
        setup_channel(0, 32'h0001_0000, 32);
        setup_channel(1, 32'h0002_0004, 48);
        setup_channel(2, 32'h0003_0100, 24);
        setup_channel(3, 32'h0004_0ff0, 40);
        for (int c = 0; c < `UDMA_N_CH; c++)
            apb_access(reg_addr(c, `UDMA_REG_CFG), 32'h1, 1'b1);
        wait_events(4'b1111);
        for (int c = 0; c < `UDMA_N_CH; c++)
            apb_access(reg_addr(c, `UDMA_REG_CFG), '0, 1'b0);
        end_test("four channels");

        // under one word, no request and no event may follow
        setup_channel(2, 32'h0005_0000, 3);
        apb_access(reg_addr(2, `UDMA_REG_CFG), 32'h1, 1'b1);
        repeat (40) @(posedge sys_clk_i);
        apb_access(reg_addr(2, `UDMA_REG_CFG), '0, 1'b0);
        end_test("short start");

        $display("tests %0d, errors %0d, words %0d", test_num - 1, err_cnt, word_cnt);
        if (err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+hdl
+incdir+bench
hdl/udma_pkg.sv
hdl/udma_apb_regs.sv
hdl/udma_tx_channel.sv
hdl/udma_l2_arbiter.sv
hdl/udma_subsystem.sv
bench/udma_checker.sv
bench/tb_udma_subsystem.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_udma_subsystem -f flist.f -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -qxF "PASS: all tests" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
